//--- common/s2m_regs_pkg.sv
package s2m_regs_pkg;

    // slave port register addresses
    localparam logic [1:0] reg_command   = 2'd0;  // burst length, go
    localparam logic [1:0] reg_status    = 2'd1;  // busy flag
    localparam logic [1:0] reg_dest_addr = 2'd2;  // destination byte address
    localparam logic [1:0] reg_length    = 2'd3;  // transfer length in words

    // command word layout
    localparam int go_bit = 15;

    // transfer length counter width
    localparam int length_width = 24;

    // programmed transfer, held by the register block
    typedef struct packed {
        logic [31:0]             dest_addr;
        logic [length_width-1:0] length;
        logic [7:0]              burst_len;
    } s2m_config_t;

endpackage

//--- common/s2m_bus_pkg.sv
package s2m_bus_pkg;

    // default stream and memory data width
    localparam int data_width = 16;

    // slave port request from the processor
    typedef struct packed {
        logic [1:0]  address;
        logic [31:0] writedata;
        logic        read;
        logic        write;
    } csr_req_t;

    // burst write master towards memory
    typedef struct packed {
        logic [31:0]               address;     // burst start address
        logic [7:0]                burstcount;  // beats in current burst
        logic [data_width/8-1:0]   byteenable;
        logic [data_width-1:0]     writedata;
        logic                      write;
    } mem_write_t;

endpackage

//--- verilog/showahead_fifo.sv
module showahead_fifo #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 512
) (
    input  logic                           clock,
    input  logic                           clock_sreset,

    input  logic                           wrreq,
    input  logic [WIDTH-1:0]               data,
    input  logic                           rdreq,
    output logic [WIDTH-1:0]               q,
    output logic [$clog2(DEPTH+1)-1:0]     usedw
);

    localparam int ptr_width = $clog2(DEPTH);

    logic [WIDTH-1:0]     mem [DEPTH];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;

    // head word always on the output
    always_comb begin
        q = mem[rd_ptr];
    end

    always_ff @(posedge clock) begin
        if (wrreq) begin
            mem[wr_ptr] <= data;
        end
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            usedw  <= '0;
        end else begin
            if (wrreq) begin
                wr_ptr <= (wr_ptr == ptr_width'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rdreq) begin
                rd_ptr <= (rd_ptr == ptr_width'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wrreq, rdreq})
                2'b10: begin
                    usedw <= usedw + 1'b1;
                end
                2'b01: begin
                    usedw <= usedw - 1'b1;
                end
                default: begin
                    // both or neither, level unchanged
                end
            endcase
        end
    end

endmodule

//--- stream_to_memory/s2m_csr.sv
module s2m_csr
    import s2m_bus_pkg::*, s2m_regs_pkg::*;
(
    input  logic         clock,
    input  logic         clock_sreset,

    input  csr_req_t     csr_req,
    output logic [31:0]  csr_readdata,
    output logic         csr_waitrequest,

    input  logic         busy,
    output s2m_config_t  cfg,
    output logic         go
);

    logic read_latency;  // second cycle of a read

    // reads stall for one cycle, writes never wait
    always_comb begin
        csr_waitrequest = csr_req.read & ~csr_req.write & ~read_latency;
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            read_latency <= 1'b0;
            go           <= 1'b0;
            cfg          <= '0;
        end else begin
            read_latency <= read_latency ? 1'b0 : csr_req.read;
            go <= csr_req.write && (csr_req.address == reg_command)
                  && csr_req.writedata[go_bit];
            if (csr_req.write) begin
                case (csr_req.address)
                    reg_command: begin
                        cfg.burst_len <= csr_req.writedata[7:0];
                    end
                    reg_dest_addr: begin
                        cfg.dest_addr <= csr_req.writedata;
                    end
                    reg_length: begin
                        cfg.length <= csr_req.writedata[length_width-1:0];
                    end
                    default: begin
                        // status is read only
                    end
                endcase
            end
        end
    end

    // readback sampled in the stall cycle, held through the second
    always_ff @(posedge clock) begin
        if (csr_req.read && !read_latency) begin
            case (csr_req.address)
                reg_command: begin
                    csr_readdata <= 32'(cfg.burst_len);
                end
                reg_status: begin
                    csr_readdata <= 32'(busy);
                end
                reg_dest_addr: begin
                    csr_readdata <= cfg.dest_addr;
                end
                default: begin
                    csr_readdata <= 32'(cfg.length);
                end
            endcase
        end
    end

endmodule

//--- stream_to_memory/s2m_burst_engine.sv
module s2m_burst_engine
    import s2m_bus_pkg::*, s2m_regs_pkg::*;
#(
    parameter int WIDTH      = data_width,
    parameter int WIDTHB     = 8,
    parameter int FIFO_DEPTH = 512
) (
    input  logic                                clock,
    input  logic                                clock_sreset,

    input  s2m_config_t                         cfg,
    input  logic                                go,
    output logic                                busy,

    input  logic [$clog2(FIFO_DEPTH+1)-1:0]     usedw,
    input  logic [WIDTH-1:0]                    head,
    output logic                                pop,

    output mem_write_t                          mem_req,
    input  logic                                mem_waitrequest
);

    localparam int bytes_per_word = WIDTH / 8;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_data,
        st_burst
    } state_t;

    state_t                  state;
    logic [31:0]             burst_addr;
    logic [length_width-1:0] words_left;  // not yet handed to a burst
    logic [WIDTHB-1:0]       beats_left;
    logic [WIDTHB-1:0]       burst_size;
    logic [WIDTHB-1:0]       next_size;
    logic                    write_r;
    logic                    beat_done;

    // shorten the final burst to what remains
    always_comb begin
        if (words_left < length_width'(cfg.burst_len)) begin
            next_size = WIDTHB'(words_left);
        end else begin
            next_size = WIDTHB'(cfg.burst_len);
        end
    end

    always_comb begin
        beat_done = write_r & ~mem_waitrequest;
        pop       = beat_done;  // head leaves with its beat
    end

    // fields stay put under waitrequest, head only moves on pop
    always_comb begin
        mem_req.address    = burst_addr;
        mem_req.burstcount = burst_size;
        mem_req.byteenable = '1;
        mem_req.writedata  = head;
        mem_req.write      = write_r;
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            state   <= st_idle;
            busy    <= 1'b0;
            write_r <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    write_r <= 1'b0;
                    if (go) begin
                        burst_addr <= cfg.dest_addr;
                        words_left <= cfg.length;
                        busy       <= 1'b1;
                        state      <= st_wait_data;
                    end
                end
                st_wait_data: begin
                    if (words_left == '0) begin  // zero length transfer
                        busy  <= 1'b0;
                        state <= st_idle;
                    end else if (usedw >= next_size) begin
                        write_r    <= 1'b1;
                        burst_size <= next_size;
                        beats_left <= next_size;
                        words_left <= words_left - length_width'(next_size);
                        state      <= st_burst;
                    end
                end
                st_burst: begin
                    if (beat_done) begin
                        beats_left <= beats_left - 1'b1;
                        if (beats_left == WIDTHB'(1)) begin
                            write_r    <= 1'b0;
                            burst_addr <= burst_addr
                                          + 32'(burst_size) * 32'(bytes_per_word);
                            if (words_left == '0) begin
                                busy  <= 1'b0;
                                state <= st_idle;
                            end else begin
                                state <= st_wait_data;
                            end
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

//--- stream_to_memory/stream_to_memory.sv
module stream_to_memory
    import s2m_bus_pkg::*, s2m_regs_pkg::*;
#(
    parameter int WIDTH      = data_width,
    parameter int WIDTHB     = 8,
    parameter int FIFO_DEPTH = 512
) (
    input  logic                                clock,
    input  logic                                clock_sreset,

    input  csr_req_t                            csr_req,
    output logic [31:0]                         csr_readdata,
    output logic                                csr_waitrequest,

    input  logic                                fifo_wrreq,
    input  logic [WIDTH-1:0]                    fifo_data,
    output logic [$clog2(FIFO_DEPTH+1)-1:0]     fifo_usedw,

    output mem_write_t                          mem_req,
    input  logic                                mem_waitrequest
);

    s2m_config_t             cfg;
    logic                    go;
    logic                    busy;
    logic                    fifo_pop;
    logic [WIDTH-1:0]        fifo_head;

    s2m_csr u_csr (
        .clock           (clock),
        .clock_sreset    (clock_sreset),
        .csr_req         (csr_req),
        .csr_readdata    (csr_readdata),
        .csr_waitrequest (csr_waitrequest),
        .busy            (busy),
        .cfg             (cfg),
        .go              (go)
    );

    showahead_fifo #(
        .WIDTH (WIDTH),
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clock        (clock),
        .clock_sreset (clock_sreset),
        .wrreq        (fifo_wrreq),
        .data         (fifo_data),
        .rdreq        (fifo_pop),
        .q            (fifo_head),
        .usedw        (fifo_usedw)
    );

    s2m_burst_engine #(
        .WIDTH      (WIDTH),
        .WIDTHB     (WIDTHB),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_engine (
        .clock           (clock),
        .clock_sreset    (clock_sreset),
        .cfg             (cfg),
        .go              (go),
        .busy            (busy),
        .usedw           (fifo_usedw),
        .head            (fifo_head),
        .pop             (fifo_pop),
        .mem_req         (mem_req),
        .mem_waitrequest (mem_waitrequest)
    );

endmodule

//--- testbench/tb_stream_to_memory.sv
module tb_stream_to_memory
    import s2m_bus_pkg::*, s2m_regs_pkg::*;
;

    localparam int FIFO_DEPTH = 512;
    localparam int n_rows     = 5;

    logic                                clock;
    logic                                clock_sreset;
    csr_req_t                            csr_req;
    logic [31:0]                         csr_readdata;
    logic                                csr_waitrequest;
    logic                                fifo_wrreq;
    logic [15:0]                         fifo_data;
    logic [$clog2(FIFO_DEPTH+1)-1:0]     fifo_usedw;
    mem_write_t                          mem_req;
    logic                                mem_waitrequest;

    // transfer table with the burst count each row should produce
    string       row_name   [n_rows] = '{"exact_multiple", "short_last", "single_word",
                                         "burst_len_one", "long_bursts"};
    logic [31:0] row_dest   [n_rows] = '{32'h0000_1000, 32'h0002_0040, 32'h0003_0100,
                                         32'h0004_0000, 32'h0005_0010};
    logic [7:0]  row_burst  [n_rows] = '{8'd8, 8'd16, 8'd8, 8'd1, 8'd64};
    int          row_words  [n_rows] = '{32, 37, 1, 5, 100};
    int          row_bursts [n_rows] = '{4, 3, 1, 5, 2};

    int          errors = 0;
    string       cur_name = "reset";
    logic        row_active = 1'b0;
    logic [7:0]  cur_burst;
    int          cur_words;
    int          beats_total;   // accepted beats in this row
    int          beat_index;    // beat within current burst
    int          bursts_seen;
    logic [31:0] burst_addr_seen;
    logic [7:0]  burst_count_seen;
    logic        stall;
    logic        prev_stalled = 1'b0;
    logic        gap_needed = 1'b0;
    mem_write_t  prev_req;
    logic [$clog2(FIFO_DEPTH+1)-1:0] prev_usedw = '0;  // fill level one cycle back
    logic [31:0] addr_q [$];
    logic [15:0] data_q [$];

    stream_to_memory #(
        .WIDTH      (16),
        .WIDTHB     (8),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_stream_to_memory (
        .clock           (clock),
        .clock_sreset    (clock_sreset),
        .csr_req         (csr_req),
        .csr_readdata    (csr_readdata),
        .csr_waitrequest (csr_waitrequest),
        .fifo_wrreq      (fifo_wrreq),
        .fifo_data       (fifo_data),
        .fifo_usedw      (fifo_usedw),
        .mem_req         (mem_req),
        .mem_waitrequest (mem_waitrequest)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("Error: %s %s expected %0h actual %0h", cur_name, what, expected, actual);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%s: %s", cur_name, what);
    endtask

    task automatic write_register(input logic [1:0] addr, input logic [31:0] value);
        @(negedge clock);
        csr_req.address   = addr;
        csr_req.writedata = value;
        csr_req.write     = 1'b1;
        @(negedge clock);
        csr_req.write     = 1'b0;
    endtask

    task automatic read_register(input logic [1:0] addr, output logic [31:0] value);
        int waits;
        @(negedge clock);
        csr_req.address = addr;
        csr_req.read    = 1'b1;
        #1;
        waits = 0;
        while (csr_waitrequest && waits < 10) begin
            @(negedge clock);
            waits++;
        end
        if (waits != 1) report_mismatch("read wait cycles", 32'd1, 32'(waits));
        value        = csr_readdata;
        csr_req.read = 1'b0;  // read completes here
    endtask

    task automatic stream_words(input int row);
        int i;
        i = 0;
        while (i < row_words[row]) begin
            @(negedge clock);
            if ($urandom_range(3) != 0) begin
                fifo_wrreq = 1'b1;
                fifo_data  = 16'(row * 4096 + i);
                i++;
            end else begin
                fifo_wrreq = 1'b0;  // gap in the stream
            end
        end
        @(negedge clock);
        fifo_wrreq = 1'b0;
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        do begin
            read_register(reg_status, status);
        end while (status[0]);
    endtask

    // memory slave, random waitrequest, beats recorded at their address
    always @(negedge clock) begin
        if (!clock_sreset) begin
            if (prev_stalled && mem_req !== prev_req)
                report_failure("master fields moved under waitrequest");
            if (gap_needed && mem_req.write) report_failure("write stayed high after a burst");
            gap_needed = 1'b0;
            stall = ($urandom_range(2) == 0);
            mem_waitrequest = stall;
            if (mem_req.write) begin
                if (mem_req.byteenable !== 2'b11)
                    report_mismatch("byteenable", 32'h3, 32'(mem_req.byteenable));
                if (!row_active || beats_total >= cur_words) begin
                    report_failure("extra beat outside the transfer");
                end else if (beat_index == 0) begin
                    burst_count_seen = (cur_words - beats_total < cur_burst)
                                       ? 8'(cur_words - beats_total) : cur_burst;
                    burst_addr_seen  = mem_req.address;
                    if (mem_req.burstcount !== burst_count_seen)
                        report_mismatch("burstcount", burst_count_seen, mem_req.burstcount);
                    if (prev_usedw < burst_count_seen)
                        report_mismatch("fill level at burst start", burst_count_seen,
                                        32'(prev_usedw));
                end else begin
                    if (mem_req.burstcount !== burst_count_seen)
                        report_mismatch("burstcount within burst", burst_count_seen,
                                        mem_req.burstcount);
                    if (mem_req.address !== burst_addr_seen)
                        report_mismatch("address within burst", burst_addr_seen, mem_req.address);
                end
                if (!stall && row_active && beats_total < cur_words) begin
                    addr_q.push_back(burst_addr_seen + 32'(beat_index * 2));
                    data_q.push_back(mem_req.writedata);
                    beats_total++;
                    beat_index++;
                    if (beat_index == int'(burst_count_seen)) begin
                        beat_index = 0;
                        bursts_seen++;
                        gap_needed = 1'b1;
                    end
                end
            end
            prev_req     = mem_req;
            prev_stalled = mem_req.write && stall;
            prev_usedw   = fifo_usedw;
        end
    end

    initial begin
        int limit;
        limit = 0;
        foreach (row_words[i]) limit += row_words[i];
        limit = limit * 40 + 2000;
        #(limit);
        $display("timeout after %0d time units, the transfer never finished", limit);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] value;
        void'($urandom(32'h7183));
        clock_sreset    = 1'b1;
        csr_req         = '0;
        fifo_wrreq      = 1'b0;
        fifo_data       = '0;
        mem_waitrequest = 1'b0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        clock_sreset = 1'b0;
        if (csr_waitrequest !== 1'b0) report_failure("waitrequest high after reset with no read");
        if (mem_req.write !== 1'b0) report_failure("write high after reset");
        for (int r = 0; r < n_rows; r++) begin
            cur_name    = row_name[r];
            cur_burst   = row_burst[r];
            cur_words   = row_words[r];
            beats_total = 0;
            beat_index  = 0;
            bursts_seen = 0;
            addr_q.delete();
            data_q.delete();
            write_register(reg_dest_addr, row_dest[r]);
            write_register(reg_length, 32'(row_words[r]));
            read_register(reg_dest_addr, value);
            if (value !== row_dest[r]) report_mismatch("reg 2 readback", row_dest[r], value);
            read_register(reg_length, value);
            if (value !== 32'(row_words[r]))
                report_mismatch("reg 3 readback", 32'(row_words[r]), value);
            read_register(reg_status, value);
            if (value !== 32'd0) report_mismatch("status before go", 32'd0, value);
            row_active = 1'b1;
            write_register(reg_command, (32'd1 << go_bit) | 32'(row_burst[r]));
            read_register(reg_command, value);
            if (value !== 32'(row_burst[r]))
                report_mismatch("reg 0 readback", 32'(row_burst[r]), value);
            read_register(reg_status, value);
            if (value !== 32'd1) report_mismatch("status after go", 32'd1, value);
            fork
                stream_words(r);
                wait_idle();
            join
            row_active = 1'b0;
            if (addr_q.size() != row_words[r])
                report_mismatch("beat count", 32'(row_words[r]), 32'(addr_q.size()));
            if (bursts_seen != row_bursts[r])
                report_mismatch("burst count", 32'(row_bursts[r]), 32'(bursts_seen));
            for (int i = 0; i < addr_q.size(); i++) begin
                if (addr_q[i] !== row_dest[r] + 32'(i * 2))
                    report_mismatch("beat address", row_dest[r] + 32'(i * 2), addr_q[i]);
                if (data_q[i] !== 16'(r * 4096 + i))
                    report_mismatch("beat data", 32'(r * 4096 + i), 32'(data_q[i]));
            end
            if (fifo_usedw !== '0) report_mismatch("fill level after row", 32'd0, 32'(fifo_usedw));
        end
        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
common/s2m_regs_pkg.sv
common/s2m_bus_pkg.sv
verilog/showahead_fifo.sv
stream_to_memory/s2m_csr.sv
stream_to_memory/s2m_burst_engine.sv
stream_to_memory/stream_to_memory.sv
testbench/tb_stream_to_memory.sv
